// File: sources.f
+incdir+tests
rtl/decode_pkg.sv
rtl/prefix_decode.sv
rtl/opcode_decode.sv
rtl/modrm_decode.sv
rtl/field_extract.sv
rtl/eip_tracker.sv
rtl/decode_top.sv
tests/tb_decode.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --top-module tb_decode -f sources.f -Mdir obj_dir -o sim_decode \
    && ./obj_dir/sim_decode > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "^Result: PASSED$" sim.log && exit 0 || { echo "simulation failed"; exit 1; }

// File: tests/tb_decode_tasks.svh
`ifndef TB_DECODE_TASKS_SVH
`define TB_DECODE_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// packet and handshake helpers
//////////////////////////////////////////////////////////////////////

// instruction in the low n bytes of val, first byte highest
function automatic logic [PACKET_W-1:0] make_packet(input logic [PACKET_W-1:0] val, input int n);
    logic [PACKET_W-1:0] pkt;
    pkt = val << (8 * (PACKET_BYTES - n));  // byte 0 to the top
    for (int i = 0; i < PACKET_BYTES - n; i++) begin
        pkt[8*i +: 8] = 8'($random(seed));  // junk after the instruction
    end
    return pkt;
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
        errors = errors + 1;
        $display("Fail %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic send_packet(input logic [PACKET_W-1:0] pkt);
    @(posedge clk);
    #5;
    in_valid  = 1'b1;
    in_packet = pkt;
    @(negedge clk);
    while (!in_ready) @(negedge clk);  // held until taken
    @(posedge clk);                    // accepted here
    #5;
    in_valid = 1'b0;
endtask

// sits at the negedge of the transfer cycle, payload stable
task automatic wait_result(input alu_op_e op, input logic [LEN_W-1:0] len);
    @(negedge clk);
    while (!(out_valid && out_ready)) @(negedge clk);
    check_value("out_op", 32'(out_op), 32'(op));
    check_value("out_length", 32'(out_length), 32'(len));
    check_value("out_eip", out_eip, exp_eip);
    exp_eip = exp_eip + 32'(len);  // sequential next eip
endtask

task automatic run_insn(input logic [PACKET_W-1:0] val, input int n, input alu_op_e op,
                        input logic [LEN_W-1:0] len);
    send_packet(make_packet(val, n));
    wait_result(op, len);
endtask

task automatic check_addr(input logic ub, input logic [2:0] b, input logic ui,
                          input logic [2:0] ix, input logic [1:0] sc, input logic [31:0] d);
    check_value("out_use_base", 32'(out_use_base), 32'(ub));
    if (ub) check_value("out_base", 32'(out_base), 32'(b));
    check_value("out_use_index", 32'(out_use_index), 32'(ui));
    if (ui) begin
        check_value("out_index", 32'(out_index), 32'(ix));
        check_value("out_scale", 32'(out_scale), 32'(sc));
    end
    check_value("out_disp", out_disp, d);
endtask

// one-cycle pulse, target picked by the caller from init > resteer > bp
task automatic pulse_redirect(input logic iv, input logic [31:0] ie, input logic rv,
                              input logic [31:0] re, input logic bv, input logic [31:0] be,
                              input logic [31:0] target);
    @(posedge clk);
    #5;
    {init_valid, init_eip, resteer_valid, resteer_eip} = {iv, ie, rv, re};
    {bp_taken, bp_eip} = {bv, be};
    @(negedge clk);
    check_value("in_ready", 32'(in_ready), 32'd0);  // no accept while redirecting
    @(posedge clk);
    #5;
    {init_valid, resteer_valid, bp_taken} = 3'b000;
    exp_eip = target;
endtask

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////

task automatic mov_imm_test();
    @(negedge clk);
    check_value("out_valid", 32'(out_valid), 32'd0);
    check_value("in_ready", 32'(in_ready), 32'd1);
    pulse_redirect(1'b1, 32'h1000, 1'b0, 32'h0, 1'b0, 32'h0, 32'h1000);
    run_insn(128'hB8_78563412, 5, OP_MOV, 4'd5);  // mov eax, imm32
    check_value("out_imm", out_imm, 32'h12345678);
    check_value("out_reg", 32'(out_reg), 32'd0);
    check_value("out_reg_is_dest", 32'(out_reg_is_dest), 32'd1);
    run_insn(128'hBB_EFBEADDE, 5, OP_MOV, 4'd5);  // ebx
    check_value("out_imm", out_imm, 32'hDEADBEEF);
    check_value("out_reg", 32'(out_reg), 32'd3);
    run_insn(128'hBF_01020304, 5, OP_MOV, 4'd5);  // edi
    check_value("out_imm", out_imm, 32'h04030201);
    check_value("out_reg", 32'(out_reg), 32'd7);
endtask

task automatic prefix_test();
    run_insn(128'hF3_90, 2, OP_NOP, 4'd2);  // rep nop
    check_value("out_rep", 32'(out_rep), 32'd1);
    check_value("out_opsize16", 32'(out_opsize16), 32'd0);
    check_value("out_seg", 32'(out_seg), 32'(SEG_DS));
    run_insn(128'h2E_26_B8_44332211, 7, OP_MOV, 4'd7);  // cs then es, es wins
    check_value("out_seg", 32'(out_seg), 32'(SEG_ES));
    check_value("out_rep", 32'(out_rep), 32'd0);
    check_value("out_imm", out_imm, 32'h11223344);
    run_insn(128'hC7_00_78563412, 6, OP_MOV, 4'd6);  // mov [eax], imm32
    check_value("out_imm", out_imm, 32'h12345678);
    run_insn(128'h66_C7_00_3412, 5, OP_MOV, 4'd5);  // imm16 form
    check_value("out_opsize16", 32'(out_opsize16), 32'd1);
    check_value("out_imm", out_imm, 32'h00001234);
    check_value("out_rm_is_mem", 32'(out_rm_is_mem), 32'd1);
    run_insn(128'hF3_66_2E_C7_45_08_CDAB, 8, OP_MOV, 4'd8);  // 3 prefixes, [ebp+8]
    check_value("out_rep", 32'(out_rep), 32'd1);
    check_value("out_opsize16", 32'(out_opsize16), 32'd1);
    check_value("out_seg", 32'(out_seg), 32'(SEG_CS));
    check_value("out_imm", out_imm, 32'h0000ABCD);
    check_addr(1'b1, 3'd5, 1'b0, 3'd0, 2'd0, 32'h8);
endtask

task automatic addressing_test();
    run_insn(128'h8B_C1, 2, OP_MOV, 4'd2);  // mov eax, ecx
    check_value("out_rm_is_mem", 32'(out_rm_is_mem), 32'd0);
    check_value("out_rm_reg", 32'(out_rm_reg), 32'd1);
    check_addr(1'b0, 3'd0, 1'b0, 3'd0, 2'd0, 32'h0);
    run_insn(128'h8B_46_F8, 3, OP_MOV, 4'd3);  // [esi-8]
    check_value("out_rm_is_mem", 32'(out_rm_is_mem), 32'd1);
    check_addr(1'b1, 3'd6, 1'b0, 3'd0, 2'd0, 32'hFFFFFFF8);
    run_insn(128'h8B_0D_78563412, 6, OP_MOV, 4'd6);  // absolute disp32
    check_value("out_reg", 32'(out_reg), 32'd1);
    check_addr(1'b0, 3'd0, 1'b0, 3'd0, 2'd0, 32'h12345678);
    run_insn(128'h03_44_D8_10, 4, OP_ADD, 4'd4);  // [eax+ebx*8+16]
    check_addr(1'b1, 3'd0, 1'b1, 3'd3, 2'd3, 32'h10);
    run_insn(128'h01_14_24, 3, OP_ADD, 4'd3);  // [esp], index 100
    check_value("out_reg", 32'(out_reg), 32'd2);
    check_value("out_reg_is_dest", 32'(out_reg_is_dest), 32'd0);
    check_addr(1'b1, 3'd4, 1'b0, 3'd0, 2'd0, 32'h0);
    run_insn(128'h8B_04_CD_00100000, 7, OP_MOV, 4'd7);  // [ecx*8+0x1000], no base
    check_addr(1'b0, 3'd0, 1'b1, 3'd1, 2'd3, 32'h00001000);
endtask

task automatic backpressure_test();
    @(posedge clk);
    #5;
    out_ready = 1'b0;  // consumer stalls
    send_packet(make_packet(128'h90, 1));
    fork
        begin
            send_packet(make_packet(128'h05_10000000, 5));
            send_packet(make_packet(128'hEB_FE, 2));
        end
        begin
            repeat (4) begin
                @(negedge clk);
                check_value("in_ready", 32'(in_ready), 32'd0);
                check_value("out_valid", 32'(out_valid), 32'd1);
                check_value("out_op", 32'(out_op), 32'(OP_NOP));
                check_value("out_length", 32'(out_length), 32'd1);
                check_value("out_eip", out_eip, exp_eip);  // nop still held
            end
            @(posedge clk);
            #5;
            out_ready = 1'b1;
            wait_result(OP_NOP, 4'd1);
            wait_result(OP_ADD, 4'd5);
            check_value("out_imm", out_imm, 32'h00000010);
            wait_result(OP_JMP, 4'd2);
            check_value("out_imm", out_imm, 32'hFFFFFFFE);
        end
    join
endtask

task automatic redirect_test();
    run_insn(128'h90, 1, OP_NOP, 4'd1);
    pulse_redirect(1'b0, 32'h0, 1'b1, 32'h2000, 1'b0, 32'h0, 32'h2000);
    run_insn(128'h89_D8, 2, OP_MOV, 4'd2);  // mov eax, ebx at resteer target
    check_value("out_reg", 32'(out_reg), 32'd3);
    check_value("out_reg_is_dest", 32'(out_reg_is_dest), 32'd0);
    run_insn(128'h90, 1, OP_NOP, 4'd1);
    pulse_redirect(1'b1, 32'h3000, 1'b0, 32'h0, 1'b1, 32'h4000, 32'h3000);  // init beats bp
    run_insn(128'h90, 1, OP_NOP, 4'd1);
endtask

task automatic branch_invalid_test();
    run_insn(128'h3E_D6, 2, OP_INVALID, 4'd2);  // unlisted opcode
    check_value("out_is_br", 32'(out_is_br), 32'd0);
    run_insn(128'h83_D0_05, 3, OP_INVALID, 4'd1);  // 83 /2 dropped
    run_insn(128'h83_C0_FF, 3, OP_ADD, 4'd3);  // add eax, -1
    check_value("out_imm", out_imm, 32'hFFFFFFFF);
    check_value("out_rm_is_mem", 32'(out_rm_is_mem), 32'd0);
    run_insn(128'hEB_80, 2, OP_JMP, 4'd2);  // jmp rel8 -128
    check_value("out_is_br", 32'(out_is_br), 32'd1);
    check_value("out_imm", out_imm, 32'hFFFFFF80);
    run_insn(128'hE9_F0FFFFFF, 5, OP_JMP, 4'd5);  // jmp rel32 -16
    check_value("out_is_br", 32'(out_is_br), 32'd1);
    check_value("out_imm", out_imm, 32'hFFFFFFF0);
endtask

`endif

// File: tests/tb_decode.sv
`default_nettype none

module tb_decode import decode_pkg::*; ();

    logic                clk;
    logic                rst_n;
    logic                in_valid;
    logic [PACKET_W-1:0] in_packet;
    logic                in_ready;
    logic                init_valid;
    logic [EIP_W-1:0]    init_eip;
    logic                resteer_valid;
    logic [EIP_W-1:0]    resteer_eip;
    logic                bp_taken;
    logic [EIP_W-1:0]    bp_eip;
    logic                out_valid;
    logic                out_ready;
    alu_op_e             out_op;
    logic                out_opsize16;
    logic                out_rep;
    seg_e                out_seg;
    logic [REG_W-1:0]    out_reg;
    logic                out_reg_is_dest;
    logic                out_rm_is_mem;
    logic [REG_W-1:0]    out_rm_reg;
    logic                out_use_base;
    logic [REG_W-1:0]    out_base;
    logic                out_use_index;
    logic [REG_W-1:0]    out_index;
    logic [SCALE_W-1:0]  out_scale;
    logic [DISP_W-1:0]   out_disp;
    logic [IMM_W-1:0]    out_imm;
    logic                out_is_br;
    logic [LEN_W-1:0]    out_length;
    logic [EIP_W-1:0]    out_eip;

    integer           seed;        // $random state
    int               checks;
    int               errors;
    int               cycles;
    int               max_cycles;  // about ten times the test length
    logic [EIP_W-1:0] exp_eip;     // eip the next result should carry

    `include "tb_decode_tasks.svh"

    decode_top u_dut (.*);

    always #20 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_packet     = '0;
        init_valid    = 1'b0;
        init_eip      = '0;
        resteer_valid = 1'b0;
        resteer_eip   = '0;
        bp_taken      = 1'b0;
        bp_eip        = '0;
        out_ready     = 1'b1;  // consumer always ready unless a test stalls it
        seed          = 18;
        checks        = 0;
        errors        = 0;
        cycles        = 0;
        max_cycles    = 3000;
        exp_eip       = '0;
        repeat (16) @(posedge clk);
        #5;
        rst_n = 1'b1;

        ////////////////////////////////////////////////////////////////////
        // directed tests
        ////////////////////////////////////////////////////////////////////
        mov_imm_test();
        prefix_test();
        addressing_test();
        backpressure_test();
        redirect_test();
        branch_invalid_test();

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/decode_top.sv
`default_nettype none

module decode_top import decode_pkg::*; (
    input  wire                 clk,
    input  wire                 rst_n,
    // fetch side
    input  wire                 in_valid,
    input  wire  [PACKET_W-1:0] in_packet,
    output logic                in_ready,
    // redirects, one-cycle pulses
    input  wire                 init_valid,
    input  wire  [EIP_W-1:0]    init_eip,
    input  wire                 resteer_valid,
    input  wire  [EIP_W-1:0]    resteer_eip,
    input  wire                 bp_taken,
    input  wire  [EIP_W-1:0]    bp_eip,
    // decoded result
    output logic                out_valid,
    input  wire                 out_ready,
    output alu_op_e             out_op,
    output logic                out_opsize16,
    output logic                out_rep,
    output seg_e                out_seg,
    output logic [REG_W-1:0]    out_reg,
    output logic                out_reg_is_dest,
    output logic                out_rm_is_mem,
    output logic [REG_W-1:0]    out_rm_reg,
    output logic                out_use_base,
    output logic [REG_W-1:0]    out_base,
    output logic                out_use_index,
    output logic [REG_W-1:0]    out_index,
    output logic [SCALE_W-1:0]  out_scale,
    output logic [DISP_W-1:0]   out_disp,
    output logic [IMM_W-1:0]    out_imm,
    output logic                out_is_br,
    output logic [LEN_W-1:0]    out_length,
    output logic [EIP_W-1:0]    out_eip
);

    logic [1:0]          num_prefixes;
    logic                rep, opsize16;
    seg_e                seg;
    logic [PACKET_W-1:0] shifted;  // packet with prefixes stripped off the top
    logic [7:0]          opcode_byte, modrm_byte, sib_byte;
    alu_op_e             op;
    logic                has_modrm, reg_is_dest, is_br;
    imm_size_e           imm_size;
    logic [REG_W-1:0]    opcode_reg, reg_field, rm_reg, base, index;
    logic                rm_is_mem, use_base, use_index, has_sib;
    logic [SCALE_W-1:0]  scale;
    logic [DSZ_W-1:0]    disp_size;
    logic [DISP_W-1:0]   disp;
    logic [IMM_W-1:0]    imm;
    logic [LEN_W-1:0]    length;
    logic [EIP_W-1:0]    eip;
    logic                redirect, accept;

    //////////////////////////////////////////////////////////////////////
    // byte slicing and decoders
    //////////////////////////////////////////////////////////////////////
    prefix_decode u_prefix (
        .packet_head (in_packet[PACKET_W-1 -: MAX_PREFIXES*8]),
        .num_prefixes(num_prefixes), .rep(rep), .opsize16(opsize16), .seg(seg)
    );

    assign shifted     = in_packet << {num_prefixes, 3'b000};
    assign opcode_byte = shifted[PACKET_W-1 -: 8];
    assign modrm_byte  = shifted[PACKET_W-9 -: 8];
    assign sib_byte    = shifted[PACKET_W-17 -: 8];

    opcode_decode u_opcode (
        .opcode_byte(opcode_byte), .modrm_reg(reg_field), .opsize16(opsize16),
        .op(op), .has_modrm(has_modrm), .reg_is_dest(reg_is_dest),
        .imm_size(imm_size), .opcode_reg(opcode_reg), .is_br(is_br)
    );

    modrm_decode u_modrm (
        .modrm_byte(modrm_byte), .sib_byte(sib_byte),
        .reg_field(reg_field), .rm_is_mem(rm_is_mem), .rm_reg(rm_reg),
        .use_base(use_base), .base(base), .use_index(use_index), .index(index),
        .scale(scale), .has_sib(has_sib), .disp_size(disp_size)
    );

    // modrm fields only count when the opcode has a modrm byte
    field_extract u_fields (
        .packet(in_packet), .num_prefixes(num_prefixes), .has_modrm(has_modrm),
        .has_sib(has_modrm && has_sib), .disp_size(has_modrm ? disp_size : '0),
        .imm_size(imm_size), .disp(disp), .imm(imm), .length(length)
    );

    //////////////////////////////////////////////////////////////////////
    // handshake and eip
    //////////////////////////////////////////////////////////////////////
    assign in_ready = !redirect && (!out_valid || out_ready);  // no accept on redirect
    assign accept   = in_valid && in_ready;

    eip_tracker u_eip (
        .clk(clk), .rst_n(rst_n),
        .init_valid(init_valid), .init_eip(init_eip),
        .resteer_valid(resteer_valid), .resteer_eip(resteer_eip),
        .bp_taken(bp_taken), .bp_eip(bp_eip),
        .advance(accept), .length(length), .eip(eip), .redirect(redirect)
    );

    //////////////////////////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;  // drained
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_op          <= op;
            out_opsize16    <= opsize16;
            out_rep         <= rep;
            out_seg         <= seg;
            out_reg         <= has_modrm ? reg_field : opcode_reg;  // B8..BF row
            out_reg_is_dest <= reg_is_dest;
            out_rm_is_mem   <= has_modrm && rm_is_mem;
            out_rm_reg      <= rm_reg;
            out_use_base    <= has_modrm && use_base;
            out_base        <= base;
            out_use_index   <= has_modrm && use_index;
            out_index       <= index;
            out_scale       <= scale;
            out_disp        <= disp;
            out_imm         <= imm;
            out_is_br       <= is_br;
            out_length      <= length;
            out_eip         <= eip;  // eip held at accept
        end
    end

    a_stall_stable : assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid &&
        $stable({out_op, out_seg, out_reg, out_disp, out_imm, out_length, out_eip}));

endmodule

`default_nettype wire

// File: rtl/eip_tracker.sv
`default_nettype none

module eip_tracker import decode_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              init_valid,
    input  wire  [EIP_W-1:0] init_eip,
    input  wire              resteer_valid,  // writeback resteer
    input  wire  [EIP_W-1:0] resteer_eip,
    input  wire              bp_taken,
    input  wire  [EIP_W-1:0] bp_eip,
    input  wire              advance,        // packet accepted this cycle
    input  wire  [LEN_W-1:0] length,
    output logic [EIP_W-1:0] eip,
    output logic             redirect
);

    assign redirect = init_valid || resteer_valid || bp_taken;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eip <= '0;
        end else if (init_valid) begin
            eip <= init_eip;     // init beats everything
        end else if (resteer_valid) begin
            eip <= resteer_eip;
        end else if (bp_taken) begin
            eip <= bp_eip;
        end else if (advance) begin
            eip <= eip + EIP_W'(length);  // next sequential instruction
        end
    end

    // the top holds off acceptance in any redirect cycle
    a_no_adv_on_redirect : assert property (
        @(posedge clk) disable iff (!rst_n) !(advance && redirect));

endmodule

`default_nettype wire

// File: rtl/field_extract.sv
`default_nettype none

module field_extract import decode_pkg::*; (
    input  wire  [PACKET_W-1:0] packet,
    input  wire  [1:0]          num_prefixes,
    input  wire                 has_modrm,
    input  wire                 has_sib,
    input  wire  [DSZ_W-1:0]    disp_size,
    input  wire  imm_size_e     imm_size,
    output logic [DISP_W-1:0]   disp,
    output logic [IMM_W-1:0]    imm,
    output logic [LEN_W-1:0]    length
);

    logic [LEN_W-1:0]    disp_off;   // first disp byte
    logic [LEN_W-1:0]    imm_off;    // first imm byte
    logic [LEN_W-1:0]    imm_bytes;
    logic [PACKET_W-1:0] disp_win;
    logic [PACKET_W-1:0] imm_win;
    logic [31:0]         disp_raw;
    logic [31:0]         imm_raw;

    // top four window bytes reassembled little-endian
    function automatic logic [31:0] le32(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    assign disp_off = LEN_W'(num_prefixes) + LEN_W'(1) + LEN_W'(has_modrm) + LEN_W'(has_sib);
    assign imm_off  = disp_off + LEN_W'(disp_size);
    assign length   = imm_off + imm_bytes;

    assign disp_win = packet << {disp_off, 3'b000};  // disp byte now at the top
    assign imm_win  = packet << {imm_off, 3'b000};
    assign disp_raw = le32(disp_win[PACKET_W-1 -: 32]);
    assign imm_raw  = le32(imm_win[PACKET_W-1 -: 32]);

    always_comb begin
        case (disp_size)
            3'd1:    disp = {{(DISP_W-8){disp_raw[7]}}, disp_raw[7:0]};  // sext
            3'd4:    disp = disp_raw;
            default: disp = '0;
        endcase
        case (imm_size)
            IMM_1: begin
                imm       = {{(IMM_W-8){imm_raw[7]}}, imm_raw[7:0]};
                imm_bytes = LEN_W'(1);
            end
            IMM_2: begin
                imm       = {{(IMM_W-16){1'b0}}, imm_raw[15:0]};  // imm16 zero-extends
                imm_bytes = LEN_W'(2);
            end
            IMM_4: begin
                imm       = imm_raw;
                imm_bytes = LEN_W'(4);
            end
            default: begin
                imm       = '0;
                imm_bytes = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/modrm_decode.sv
`default_nettype none

module modrm_decode import decode_pkg::*; (
    input  wire  [7:0]         modrm_byte,
    input  wire  [7:0]         sib_byte,
    output logic [REG_W-1:0]   reg_field,
    output logic               rm_is_mem,
    output logic [REG_W-1:0]   rm_reg,
    output logic               use_base,
    output logic [REG_W-1:0]   base,
    output logic               use_index,
    output logic [REG_W-1:0]   index,
    output logic [SCALE_W-1:0] scale,
    output logic               has_sib,
    output logic [DSZ_W-1:0]   disp_size
);

    logic [1:0]       mod_f;
    logic [REG_W-1:0] rm_f;
    logic             no_base;  // mod 00 disp32-only forms

    assign mod_f     = modrm_byte[7:6];
    assign rm_f      = modrm_byte[2:0];
    assign reg_field = modrm_byte[5:3];
    assign rm_reg    = rm_f;  // register operand when mod 11

    assign rm_is_mem = (mod_f != 2'b11);
    assign has_sib   = rm_is_mem && (rm_f == 3'b100);

    // rm 101 or sib base 101 under mod 00 means disp32 and no base
    assign no_base  = (mod_f == 2'b00) &&
                      (has_sib ? (sib_byte[2:0] == 3'b101) : (rm_f == 3'b101));
    assign use_base = rm_is_mem && !no_base;
    assign base     = has_sib ? sib_byte[2:0] : rm_f;

    assign use_index = has_sib && (sib_byte[5:3] != 3'b100);  // 100 = no index
    assign index     = sib_byte[5:3];
    assign scale     = has_sib ? sib_byte[7:6] : '0;

    always_comb begin
        case (mod_f)
            2'b01:   disp_size = 3'd1;                 // disp8
            2'b10:   disp_size = 3'd4;                 // disp32
            2'b00:   disp_size = no_base ? 3'd4 : 3'd0;
            default: disp_size = 3'd0;                 // register form
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/opcode_decode.sv
`default_nettype none

module opcode_decode import decode_pkg::*; (
    input  wire  [7:0]       opcode_byte,
    input  wire  [REG_W-1:0] modrm_reg,    // /digit for 83 and C7
    input  wire              opsize16,
    output alu_op_e          op,
    output logic             has_modrm,
    output logic             reg_is_dest,
    output imm_size_e        imm_size,
    output logic [REG_W-1:0] opcode_reg,
    output logic             is_br
);

    imm_size_e imm_full;  // imm32, or imm16 under 66
    logic      ext_zero;

    assign imm_full = opsize16 ? IMM_2 : IMM_4;
    assign ext_zero = (modrm_reg == '0);

    always_comb begin
        // defaults describe an invalid opcode, no modrm and no imm
        op          = OP_INVALID;
        has_modrm   = 1'b0;
        reg_is_dest = 1'b0;
        imm_size    = IMM_NONE;
        opcode_reg  = '0;  // eAX for 05
        is_br       = 1'b0;
        if (opcode_byte[7:3] == OPC_MOV_R_I[7:3]) begin
            // B8..BF, register in the low bits
            op          = OP_MOV;
            reg_is_dest = 1'b1;
            imm_size    = imm_full;
            opcode_reg  = opcode_byte[REG_W-1:0];
        end else begin
            case (opcode_byte)
                OPC_ADD_RM_R, OPC_ADD_R_RM: begin
                    op          = OP_ADD;
                    has_modrm   = 1'b1;
                    reg_is_dest = opcode_byte[1];  // d bit
                end
                OPC_ADD_EAX_I: begin
                    op          = OP_ADD;
                    reg_is_dest = 1'b1;
                    imm_size    = imm_full;
                end
                OPC_GRP1_I8: if (ext_zero) begin
                    op        = OP_ADD;
                    has_modrm = 1'b1;
                    imm_size  = IMM_1;
                end
                OPC_MOV_RM_R, OPC_MOV_R_RM: begin
                    op          = OP_MOV;
                    has_modrm   = 1'b1;
                    reg_is_dest = opcode_byte[1];
                end
                OPC_MOV_RM_I: if (ext_zero) begin
                    op        = OP_MOV;
                    has_modrm = 1'b1;
                    imm_size  = imm_full;
                end
                OPC_JMP_R8: begin
                    op       = OP_JMP;
                    imm_size = IMM_1;
                    is_br    = 1'b1;
                end
                OPC_JMP_R32: begin
                    op       = OP_JMP;
                    imm_size = IMM_4;  // rel32 ignores 66 here
                    is_br    = 1'b1;
                end
                OPC_NOP: op = OP_NOP;
                default: op = OP_INVALID;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/prefix_decode.sv
`default_nettype none

module prefix_decode import decode_pkg::*; (
    input  wire  [MAX_PREFIXES*8-1:0] packet_head,  // byte 0 on top
    output logic [1:0]                num_prefixes,
    output logic                      rep,
    output logic                      opsize16,
    output seg_e                      seg
);

    logic [7:0] cur_byte;
    logic       scanning;  // still inside the prefix run

    always_comb begin
        num_prefixes = '0;
        rep          = 1'b0;
        opsize16     = 1'b0;
        seg          = SEG_DS;  // no override
        scanning     = 1'b1;
        cur_byte     = '0;
        for (int i = 0; i < MAX_PREFIXES; i++) begin
            cur_byte = packet_head[MAX_PREFIXES*8-1-8*i -: 8];
            if (scanning) begin
                case (cur_byte)
                    PFX_REP:    rep = 1'b1;
                    PFX_OPSIZE: opsize16 = 1'b1;
                    PFX_ES:     seg = SEG_ES;  // later overrides win
                    PFX_CS:     seg = SEG_CS;
                    PFX_SS:     seg = SEG_SS;
                    PFX_DS:     seg = SEG_DS;
                    PFX_FS:     seg = SEG_FS;
                    PFX_GS:     seg = SEG_GS;
                    default:    scanning = 1'b0;  // first non-prefix ends the run
                endcase
                if (scanning) begin
                    num_prefixes = num_prefixes + 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/decode_pkg.sv
`default_nettype none

package decode_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////
    localparam int PACKET_BYTES = 16;
    localparam int PACKET_W     = PACKET_BYTES * 8;  // byte 0 in the top bits
    localparam int EIP_W        = 32;
    localparam int LEN_W        = 4;
    localparam int MAX_LEN      = 14;  // longest legal instruction in the subset
    localparam int MAX_PREFIXES = 3;
    localparam int REG_W        = 3;
    localparam int SCALE_W      = 2;
    localparam int DISP_W       = 32;
    localparam int IMM_W        = 32;
    localparam int DSZ_W        = 3;   // disp size in bytes, 0 / 1 / 4

    //////////////////////////////////////////////////////////////////////
    // prefix bytes
    //////////////////////////////////////////////////////////////////////
    localparam logic [7:0] PFX_REP    = 8'hF3;
    localparam logic [7:0] PFX_OPSIZE = 8'h66;
    localparam logic [7:0] PFX_ES     = 8'h26;
    localparam logic [7:0] PFX_CS     = 8'h2E;
    localparam logic [7:0] PFX_SS     = 8'h36;
    localparam logic [7:0] PFX_DS     = 8'h3E;
    localparam logic [7:0] PFX_FS     = 8'h64;
    localparam logic [7:0] PFX_GS     = 8'h65;

    //////////////////////////////////////////////////////////////////////
    // one-byte opcodes
    //////////////////////////////////////////////////////////////////////
    localparam logic [7:0] OPC_ADD_RM_R  = 8'h01;
    localparam logic [7:0] OPC_ADD_R_RM  = 8'h03;
    localparam logic [7:0] OPC_ADD_EAX_I = 8'h05;
    localparam logic [7:0] OPC_GRP1_I8   = 8'h83;  // only /0 kept
    localparam logic [7:0] OPC_MOV_RM_R  = 8'h89;
    localparam logic [7:0] OPC_MOV_R_RM  = 8'h8B;
    localparam logic [7:0] OPC_MOV_R_I   = 8'hB8;  // row base, B8..BF
    localparam logic [7:0] OPC_MOV_RM_I  = 8'hC7;  // only /0 kept
    localparam logic [7:0] OPC_JMP_R8    = 8'hEB;
    localparam logic [7:0] OPC_JMP_R32   = 8'hE9;
    localparam logic [7:0] OPC_NOP       = 8'h90;

    typedef enum logic [2:0] {
        OP_NOP,
        OP_ADD,
        OP_MOV,
        OP_JMP,
        OP_INVALID
    } alu_op_e;

    // x86 sreg numbering
    typedef enum logic [2:0] {
        SEG_ES = 3'd0,
        SEG_CS = 3'd1,
        SEG_SS = 3'd2,
        SEG_DS = 3'd3,  // default segment
        SEG_FS = 3'd4,
        SEG_GS = 3'd5
    } seg_e;

    typedef enum logic [1:0] {
        IMM_NONE,
        IMM_1,
        IMM_2,
        IMM_4
    } imm_size_e;

endpackage

`default_nettype wire
